//--- hw/tlu_consts.svh
`ifndef TLU_CONSTS_SVH
`define TLU_CONSTS_SVH

// wishbone slave
`define TLU_WB_ADR_W 4
`define TLU_WB_DAT_W 8

// trigger number, trigger counter and timestamp
`define TLU_NUM_W 32

// clock-cycle field, 0 selects 32 bits
`define TLU_CYC_W 5

// CMD_CLK periods per TLU clock period
`define TLU_DIVISOR 16

`define TLU_SYNC_STAGES 3

// synchronizer channels
`define TLU_NUM_INPUTS 4
`define TLU_CH_RJ45_TRIG 0
`define TLU_CH_LEMO_TRIG 1
`define TLU_CH_RJ45_RST 2
`define TLU_CH_LEMO_RST 3

`endif

//--- hw/tlu_mode_pkg.sv
`default_nettype none

package tlu_mode_pkg;

    // TLU operating modes as written to the control register
    typedef enum logic [1:0] {
        // RJ45 disabled, no handshake
        TLU_MODE_LEMO_ONLY = 2'b00,
        TLU_MODE_NO_HS     = 2'b01,
        // busy until the trigger drops
        TLU_MODE_SIMPLE_HS = 2'b10,
        // busy plus trigger number readout
        TLU_MODE_DATA_HS   = 2'b11
    } tlu_mode_t;

    // handshake FSM
    typedef enum logic [2:0] {
        ST_IDLE     = 3'd0,
        ST_START    = 3'd1,
        ST_WAIT_LOW = 3'd2,
        ST_SHIFT    = 3'd3,
        ST_DONE     = 3'd4
    } tlu_state_t;

endpackage

`default_nettype wire

//--- hw/tlu_regmap_pkg.sv
`default_nettype none

package tlu_regmap_pkg;

    // byte addresses of the wishbone register block
    typedef enum logic [3:0] {
        REG_CTRL       = 4'd0,
        REG_CLK_CYCLES = 4'd1,
        // last TLU trigger number, read only
        REG_TLU_NUM_0  = 4'd4,
        REG_TLU_NUM_1  = 4'd5,
        REG_TLU_NUM_2  = 4'd6,
        REG_TLU_NUM_3  = 4'd7,
        // trigger counter, byte 3 loads the word
        REG_TRIG_CNT_0 = 4'd8,
        REG_TRIG_CNT_1 = 4'd9,
        REG_TRIG_CNT_2 = 4'd10,
        REG_TRIG_CNT_3 = 4'd11
    } tlu_reg_addr_t;

endpackage

`default_nettype wire

//--- hw/tlu_input_sync.sv
`default_nettype none
`timescale 1ns/100ps

`include "tlu_consts.svh"

module tlu_input_sync
(
    input  wire  clk,
    input  wire  rst,
    input  wire  async_in,
    output logic level,
    output logic rise
);

    logic [`TLU_SYNC_STAGES-1:0] chain;
    logic                        level_dly;

    // metastability chain, last stage is the clean level
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            chain     <= '0;
            level_dly <= 1'b0;
        end
        else
        begin
            chain     <= {chain[`TLU_SYNC_STAGES-2:0], async_in};
            level_dly <= chain[`TLU_SYNC_STAGES-1];
        end
    end

    assign level = chain[`TLU_SYNC_STAGES-1];

    // one cycle flag on the first high cycle
    assign rise = chain[`TLU_SYNC_STAGES-1] & ~level_dly;

endmodule

`default_nettype wire

//--- hw/tlu_port_select.sv
`default_nettype none
`timescale 1ns/100ps

`include "tlu_consts.svh"

module tlu_port_select import tlu_mode_pkg::*;
(
    input  wire                        clk,
    input  wire                        rst,
    input  wire tlu_mode_t             mode,
    input  wire [`TLU_NUM_INPUTS-1:0]  sync_level,
    input  wire [`TLU_NUM_INPUTS-1:0]  sync_rise,
    output logic                       rj45_enabled,
    output logic                       trig_level,
    output logic                       trig_rise,
    output logic                       rst_rise
);

    logic rj45_unplugged;

    // an open RJ45 jack pulls both lines high
    assign rj45_unplugged = sync_level[`TLU_CH_RJ45_TRIG] & sync_level[`TLU_CH_RJ45_RST];

    always_ff @(posedge clk)
    begin
        if (rst)
            rj45_enabled <= 1'b0;
        else if (mode == TLU_MODE_LEMO_ONLY || (rj45_unplugged && !rj45_enabled))
            rj45_enabled <= 1'b0;
        else
            rj45_enabled <= 1'b1;
    end

    assign trig_level = rj45_enabled ? sync_level[`TLU_CH_RJ45_TRIG]
                                     : sync_level[`TLU_CH_LEMO_TRIG];
    assign trig_rise  = rj45_enabled ? sync_rise[`TLU_CH_RJ45_TRIG]
                                     : sync_rise[`TLU_CH_LEMO_TRIG];
    assign rst_rise   = rj45_enabled ? sync_rise[`TLU_CH_RJ45_RST]
                                     : sync_rise[`TLU_CH_LEMO_RST];

endmodule

`default_nettype wire

//--- hw/tlu_handshake_fsm.sv
`default_nettype none
`timescale 1ns/100ps

`include "tlu_consts.svh"

module tlu_handshake_fsm import tlu_mode_pkg::*;
(
    input  wire                    clk,
    input  wire                    rst,
    input  wire tlu_mode_t         mode,
    input  wire [`TLU_CYC_W-1:0]   clk_cycles,
    input  wire                    cmd_ready,
    input  wire                    trig_level,
    input  wire                    trig_rise,
    output logic                   start_flag,
    output logic                   tlu_busy,
    output logic                   tlu_clock,
    output logic                   tlu_num_valid,
    output logic [`TLU_NUM_W-1:0]  tlu_num
);

    localparam int HALF_PERIOD = `TLU_DIVISOR / 2;
    localparam int DIV_W       = $clog2(HALF_PERIOD);

    tlu_state_t             state;
    tlu_state_t             state_nxt;
    logic [DIV_W-1:0]       div_cnt;
    logic                   div_tick;
    logic [`TLU_CYC_W-1:0]  bit_cnt;
    logic [`TLU_CYC_W-1:0]  last_bit;
    logic                   sample;
    logic [`TLU_NUM_W-1:0]  shreg;

    assign div_tick = (div_cnt == DIV_W'(HALF_PERIOD - 1));
    // wraps so that clk_cycles of 0 ends after bit 31
    assign last_bit = clk_cycles - 1'b1;
    // falling edge of the TLU clock
    assign sample   = div_tick & tlu_clock;

    always_comb
    begin
        state_nxt = state;
        case (state)
            ST_IDLE:
                if (trig_rise && cmd_ready)
                    state_nxt = ST_START;
            ST_START:
                if (mode == TLU_MODE_SIMPLE_HS)
                    state_nxt = ST_WAIT_LOW;
                else if (mode == TLU_MODE_DATA_HS)
                    state_nxt = ST_SHIFT;
                else
                    state_nxt = ST_IDLE;
            ST_SHIFT:
                if (sample && bit_cnt == last_bit)
                    state_nxt = ST_DONE;
            ST_DONE:
                state_nxt = ST_WAIT_LOW;
            ST_WAIT_LOW:
                if (!trig_level)
                    state_nxt = ST_IDLE;
            default:
                state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            state <= ST_IDLE;
        else
            state <= state_nxt;
    end

    // divided TLU clock, only runs while shifting
    always_ff @(posedge clk)
    begin
        if (rst || state != ST_SHIFT)
        begin
            div_cnt   <= '0;
            tlu_clock <= 1'b0;
            bit_cnt   <= '0;
        end
        else
        begin
            div_cnt <= div_tick ? '0 : div_cnt + 1'b1;
            if (div_tick)
                tlu_clock <= ~tlu_clock;
            if (sample)
                bit_cnt <= bit_cnt + 1'b1;
        end
    end

    // LSB arrives first, upper bits stay zero
    always_ff @(posedge clk)
    begin
        if (state == ST_START)
            shreg <= '0;
        else if (state == ST_SHIFT && sample)
            shreg[bit_cnt] <= trig_level;
    end

    assign start_flag    = (state == ST_START);
    assign tlu_num_valid = (state == ST_DONE);
    assign tlu_num       = shreg;

    // busy only in the handshake modes
    assign tlu_busy = (state == ST_SHIFT) || (state == ST_DONE) || (state == ST_WAIT_LOW)
                      || (state == ST_START && (mode == TLU_MODE_SIMPLE_HS
                                                || mode == TLU_MODE_DATA_HS));

endmodule

`default_nettype wire

//--- hw/tlu_registers.sv
`default_nettype none
`timescale 1ns/100ps

`include "tlu_consts.svh"

module tlu_registers import tlu_mode_pkg::*; import tlu_regmap_pkg::*;
(
    input  wire                       clk,
    input  wire                       rst,
    input  wire [`TLU_WB_ADR_W-1:0]   wb_adr,
    input  wire [`TLU_WB_DAT_W-1:0]   wb_dat_w,
    output logic [`TLU_WB_DAT_W-1:0]  wb_dat_r,
    input  wire                       wb_we,
    input  wire                       wb_cyc,
    input  wire                       wb_stb,
    output logic                      wb_ack,
    input  wire                       start_flag,
    input  wire                       cmd_ext_start_enable,
    input  wire                       rst_rise,
    input  wire                       tlu_num_valid,
    input  wire [`TLU_NUM_W-1:0]      tlu_num,
    output tlu_mode_t                 mode,
    output logic [`TLU_CYC_W-1:0]     clk_cycles,
    output logic [`TLU_NUM_W-1:0]     timestamp
);

    localparam int HI_W = `TLU_NUM_W - `TLU_WB_DAT_W;

    tlu_reg_addr_t          addr;
    logic                   wb_req;
    logic                   wr_req;
    logic                   rd_req;
    logic                   enable_reset;
    logic                   tlu_rst;
    logic [HI_W-1:0]        cnt_stage;
    logic [`TLU_NUM_W-1:0]  trig_cnt;
    logic [`TLU_NUM_W-1:0]  tlu_num_reg;
    // upper three bytes, frozen by a read of byte 0
    logic [HI_W-1:0]        tlu_snap;
    logic [HI_W-1:0]        cnt_snap;

    assign addr    = tlu_reg_addr_t'(wb_adr);
    assign wb_req  = wb_cyc & wb_stb & ~wb_ack;
    assign wr_req  = wb_req & wb_we;
    assign rd_req  = wb_req & ~wb_we;
    assign tlu_rst = rst_rise & enable_reset;

    // ack and configuration
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            wb_ack       <= 1'b0;
            mode         <= TLU_MODE_LEMO_ONLY;
            enable_reset <= 1'b0;
            clk_cycles   <= '0;
            cnt_stage    <= '0;
        end
        else
        begin
            wb_ack <= wb_req;
            if (wr_req)
            begin
                case (addr)
                    REG_CTRL:
                    begin
                        mode         <= tlu_mode_t'(wb_dat_w[1:0]);
                        enable_reset <= wb_dat_w[2];
                    end
                    REG_CLK_CYCLES: clk_cycles <= wb_dat_w[`TLU_CYC_W-1:0];
                    REG_TRIG_CNT_0: cnt_stage[7:0] <= wb_dat_w;
                    REG_TRIG_CNT_1: cnt_stage[15:8] <= wb_dat_w;
                    REG_TRIG_CNT_2: cnt_stage[23:16] <= wb_dat_w;
                    default: ;
                endcase
            end
        end
    end

    // saturating trigger counter
    always_ff @(posedge clk)
    begin
        if (rst || tlu_rst)
            trig_cnt <= '0;
        else if (wr_req && addr == REG_TRIG_CNT_3)
            trig_cnt <= {wb_dat_w, cnt_stage};
        else if (start_flag && cmd_ext_start_enable && trig_cnt != '1)
            trig_cnt <= trig_cnt + 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (rst || tlu_rst)
            timestamp <= '0;
        else
            timestamp <= timestamp + 1'b1;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            tlu_num_reg <= '0;
            tlu_snap    <= '0;
            cnt_snap    <= '0;
        end
        else
        begin
            if (tlu_num_valid)
                tlu_num_reg <= tlu_num;
            if (rd_req && addr == REG_TLU_NUM_0)
                tlu_snap <= tlu_num_reg[`TLU_NUM_W-1:`TLU_WB_DAT_W];
            if (rd_req && addr == REG_TRIG_CNT_0)
                cnt_snap <= trig_cnt[`TLU_NUM_W-1:`TLU_WB_DAT_W];
        end
    end

    // read data lands together with ack
    always_ff @(posedge clk)
    begin
        if (rd_req)
        begin
            case (addr)
                REG_CTRL:       wb_dat_r <= {{(`TLU_WB_DAT_W-3){1'b0}}, enable_reset, mode};
                REG_CLK_CYCLES: wb_dat_r <= {{(`TLU_WB_DAT_W-`TLU_CYC_W){1'b0}}, clk_cycles};
                REG_TLU_NUM_0:  wb_dat_r <= tlu_num_reg[7:0];
                REG_TLU_NUM_1:  wb_dat_r <= tlu_snap[7:0];
                REG_TLU_NUM_2:  wb_dat_r <= tlu_snap[15:8];
                REG_TLU_NUM_3:  wb_dat_r <= tlu_snap[23:16];
                REG_TRIG_CNT_0: wb_dat_r <= trig_cnt[7:0];
                REG_TRIG_CNT_1: wb_dat_r <= cnt_snap[7:0];
                REG_TRIG_CNT_2: wb_dat_r <= cnt_snap[15:8];
                REG_TRIG_CNT_3: wb_dat_r <= cnt_snap[23:16];
                default:        wb_dat_r <= '0;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hw/tlu_controller_top.sv
`default_nettype none
`timescale 1ns/100ps

`include "tlu_consts.svh"

module tlu_controller_top import tlu_mode_pkg::*;
(
    input  wire                       CMD_CLK,
    input  wire                       RST,
    input  wire [`TLU_WB_ADR_W-1:0]   wb_adr,
    input  wire [`TLU_WB_DAT_W-1:0]   wb_dat_w,
    output logic [`TLU_WB_DAT_W-1:0]  wb_dat_r,
    input  wire                       wb_we,
    input  wire                       wb_cyc,
    input  wire                       wb_stb,
    output logic                      wb_ack,
    input  wire                       rj45_trigger,
    input  wire                       lemo_trigger,
    input  wire                       rj45_reset,
    input  wire                       lemo_reset,
    input  wire                       cmd_ready,
    input  wire                       cmd_ext_start_enable,
    output logic                      cmd_ext_start_flag,
    output logic                      tlu_busy,
    output logic                      tlu_clock,
    output logic                      rj45_enabled,
    output logic [`TLU_NUM_W-1:0]     timestamp
);

    wire [`TLU_NUM_INPUTS-1:0]  async_in;
    wire [`TLU_NUM_INPUTS-1:0]  sync_level;
    wire [`TLU_NUM_INPUTS-1:0]  sync_rise;
    wire                        trig_level;
    wire                        trig_rise;
    wire                        rst_rise;
    wire tlu_mode_t             mode;
    wire [`TLU_CYC_W-1:0]       clk_cycles;
    wire                        tlu_num_valid;
    wire [`TLU_NUM_W-1:0]       tlu_num;

    // channel order as in the consts header
    assign async_in[`TLU_CH_RJ45_TRIG] = rj45_trigger;
    assign async_in[`TLU_CH_LEMO_TRIG] = lemo_trigger;
    assign async_in[`TLU_CH_RJ45_RST]  = rj45_reset;
    assign async_in[`TLU_CH_LEMO_RST]  = lemo_reset;

    genvar i;
    generate
        for (i = 0; i < `TLU_NUM_INPUTS; i++)
        begin : g_sync
            tlu_input_sync input_sync_inst (
                .clk      (CMD_CLK),
                .rst      (RST),
                .async_in (async_in[i]),
                .level    (sync_level[i]),
                .rise     (sync_rise[i])
            );
        end
    endgenerate

    tlu_port_select port_select_inst (
        .clk          (CMD_CLK),
        .rst          (RST),
        .mode         (mode),
        .sync_level   (sync_level),
        .sync_rise    (sync_rise),
        .rj45_enabled (rj45_enabled),
        .trig_level   (trig_level),
        .trig_rise    (trig_rise),
        .rst_rise     (rst_rise)
    );

    tlu_handshake_fsm handshake_fsm_inst (
        .clk           (CMD_CLK),
        .rst           (RST),
        .mode          (mode),
        .clk_cycles    (clk_cycles),
        .cmd_ready     (cmd_ready),
        .trig_level    (trig_level),
        .trig_rise     (trig_rise),
        .start_flag    (cmd_ext_start_flag),
        .tlu_busy      (tlu_busy),
        .tlu_clock     (tlu_clock),
        .tlu_num_valid (tlu_num_valid),
        .tlu_num       (tlu_num)
    );

    tlu_registers registers_inst (
        .clk                  (CMD_CLK),
        .rst                  (RST),
        .wb_adr               (wb_adr),
        .wb_dat_w             (wb_dat_w),
        .wb_dat_r             (wb_dat_r),
        .wb_we                (wb_we),
        .wb_cyc               (wb_cyc),
        .wb_stb               (wb_stb),
        .wb_ack               (wb_ack),
        .start_flag           (cmd_ext_start_flag),
        .cmd_ext_start_enable (cmd_ext_start_enable),
        .rst_rise             (rst_rise),
        .tlu_num_valid        (tlu_num_valid),
        .tlu_num              (tlu_num),
        .mode                 (mode),
        .clk_cycles           (clk_cycles),
        .timestamp            (timestamp)
    );

endmodule

`default_nettype wire

//--- verification/tlu_controller_properties.sv
`default_nettype none
`timescale 1ns/100ps

module tlu_controller_properties
(
    input wire clk,
    input wire rst,
    input wire wb_ack,
    input wire cmd_ready,
    input wire start_flag,
    input wire tlu_busy,
    input wire tlu_clock
);

    // ack lasts exactly one cycle
    ack_width: assert property (@(posedge clk) disable iff (rst) wb_ack |=> !wb_ack)
        else $error("wb_ack held for more than one cycle");

    start_width: assert property (@(posedge clk) disable iff (rst) start_flag |=> !start_flag)
        else $error("start flag held for more than one cycle");

    // a trigger is only accepted while the sequencer is ready
    start_ready: assert property (@(posedge clk) disable iff (rst)
                                  start_flag |-> $past(cmd_ready))
        else $error("start flag without cmd_ready");

    clock_idle: assert property (@(posedge clk) disable iff (rst) !tlu_busy |-> !tlu_clock)
        else $error("tlu_clock high while not busy");

endmodule

bind tlu_controller_top tlu_controller_properties properties_inst (
    .clk        (CMD_CLK),
    .rst        (RST),
    .wb_ack     (wb_ack),
    .cmd_ready  (cmd_ready),
    .start_flag (cmd_ext_start_flag),
    .tlu_busy   (tlu_busy),
    .tlu_clock  (tlu_clock)
);

`default_nettype wire

//--- verification/tlu_controller_tb.sv
`default_nettype none
`timescale 1ns/100ps

`include "tlu_consts.svh"

module tlu_controller_tb import tlu_mode_pkg::*; import tlu_regmap_pkg::*;;

    // sync depth plus start latency, with margin
    localparam int SETTLE = `TLU_SYNC_STAGES + 4;
    localparam int ROW_CYCLES = 32 * `TLU_DIVISOR + 200;

    typedef enum
    {
        OP_WR,
        OP_RD,
        OP_CNT,
        OP_PULSE,
        OP_LINES,
        OP_ENABLE,
        OP_READY,
        OP_RJ45,
        OP_TS_SAVE,
        OP_TS_LESS,
        OP_HS,
        OP_DATA
    } step_op_t;

    typedef struct
    {
        step_op_t    op;
        logic [3:0]  addr;
        logic [31:0] data;
        logic [31:0] exp;
    } step_t;

    logic        CMD_CLK;
    logic        RST;
    logic [3:0]  wb_adr;
    logic [7:0]  wb_dat_w;
    logic [7:0]  wb_dat_r;
    logic        wb_we;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_ack;
    logic        rj45_trigger;
    logic        lemo_trigger;
    logic        rj45_reset;
    logic        lemo_reset;
    logic        cmd_ready;
    logic        cmd_ext_start_enable;
    logic        cmd_ext_start_flag;
    logic        tlu_busy;
    logic        tlu_clock;
    logic        rj45_enabled;
    logic [31:0] timestamp;

    step_t       steps[$];
    integer      seed;
    int          check_count;
    int          error_count;
    int          cycle_count;
    int          timeout_limit;
    int          clk_rises;
    logic        tlu_clock_q;
    logic [31:0] ts_saved;

    tlu_controller_top tlu_controller_top_inst (
        .CMD_CLK              (CMD_CLK),
        .RST                  (RST),
        .wb_adr               (wb_adr),
        .wb_dat_w             (wb_dat_w),
        .wb_dat_r             (wb_dat_r),
        .wb_we                (wb_we),
        .wb_cyc               (wb_cyc),
        .wb_stb               (wb_stb),
        .wb_ack               (wb_ack),
        .rj45_trigger         (rj45_trigger),
        .lemo_trigger         (lemo_trigger),
        .rj45_reset           (rj45_reset),
        .lemo_reset           (lemo_reset),
        .cmd_ready            (cmd_ready),
        .cmd_ext_start_enable (cmd_ext_start_enable),
        .cmd_ext_start_flag   (cmd_ext_start_flag),
        .tlu_busy             (tlu_busy),
        .tlu_clock            (tlu_clock),
        .rj45_enabled         (rj45_enabled),
        .timestamp            (timestamp)
    );

    always #4 CMD_CLK = ~CMD_CLK;

    always @(posedge CMD_CLK)
    begin
        cycle_count <= cycle_count + 1;
        if (timeout_limit != 0 && cycle_count > timeout_limit)
        begin
            $display("timeout: the run did not finish within %0d cycles", timeout_limit);
            $display("TB FAILED");
            $finish;
        end
    end

    // count TLU clock rising edges
    always @(negedge CMD_CLK)
    begin
        if (tlu_clock && !tlu_clock_q)
            clk_rises = clk_rises + 1;
        tlu_clock_q = tlu_clock;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        check_count++;
        if (got !== exp)
        begin
            error_count++;
            $display("MISMATCH %s: got 0x%08h expected 0x%08h at %0t", name, got, exp, $time);
        end
    endtask

    function automatic void add_step(step_op_t op, logic [3:0] addr, logic [31:0] data,
                                     logic [31:0] exp);
        step_t s;
        s.op   = op;
        s.addr = addr;
        s.data = data;
        s.exp  = exp;
        steps.push_back(s);
    endfunction

    // control byte layout, mode in 1:0 and enable_reset in bit 2
    function automatic logic [31:0] ctrl_byte(tlu_mode_t mode, logic enable_reset);
        return {29'd0, enable_reset, mode};
    endfunction

    task automatic wb_access(input logic we, input logic [3:0] adr, input logic [7:0] wdat,
                             output logic [7:0] rdat);
        @(posedge CMD_CLK);
        wb_adr   <= adr;
        wb_dat_w <= wdat;
        wb_we    <= we;
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        do
            @(negedge CMD_CLK);
        while (!wb_ack);
        rdat = wb_dat_r;
        @(posedge CMD_CLK);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
        // a second ack would show up here
        @(negedge CMD_CLK);
        check_value("wb_ack", {31'd0, wb_ack}, 32'd0);
    endtask

    // byte 0 first so the upper bytes come from its snapshot
    task automatic read_word(input logic [3:0] base, output logic [31:0] word);
        logic [7:0] rdat;
        for (int b = 0; b < 4; b++)
        begin
            wb_access(1'b0, base + 4'(b), 8'h00, rdat);
            word[8*b +: 8] = rdat;
        end
    endtask

    task automatic drive_line(input logic [3:0] line, input logic val);
        case (line)
            `TLU_CH_RJ45_TRIG: rj45_trigger <= val;
            `TLU_CH_LEMO_TRIG: lemo_trigger <= val;
            `TLU_CH_RJ45_RST:  rj45_reset <= val;
            default:           lemo_reset <= val;
        endcase
    endtask

    task automatic pulse_line(input logic [3:0] line, input logic exp_start);
        logic seen;
        seen = 1'b0;
        @(posedge CMD_CLK);
        drive_line(line, 1'b1);
        for (int i = 0; i < SETTLE; i++)
        begin
            @(negedge CMD_CLK);
            if (cmd_ext_start_flag)
                seen = 1'b1;
        end
        @(posedge CMD_CLK);
        drive_line(line, 1'b0);
        repeat (SETTLE) @(negedge CMD_CLK);
        check_value("cmd_ext_start_flag", {31'd0, seen}, {31'd0, exp_start});
    endtask

    task automatic run_simple_hs();
        int rises_before;
        rises_before = clk_rises;
        @(posedge CMD_CLK);
        rj45_trigger <= 1'b1;
        do
            @(negedge CMD_CLK);
        while (!tlu_busy);
        // busy must hold while the trigger stays high
        repeat (`TLU_DIVISOR) @(negedge CMD_CLK);
        check_value("tlu_busy", {31'd0, tlu_busy}, 32'd1);
        @(posedge CMD_CLK);
        rj45_trigger <= 1'b0;
        do
            @(negedge CMD_CLK);
        while (tlu_busy);
        check_value("tlu_clock_rises", clk_rises - rises_before, 32'd0);
    endtask

    // TLU model, presents bit k after the k-th rising TLU clock edge
    task automatic run_data_hs(input logic [4:0] n_cyc);
        int          n;
        int          k;
        int          falls;
        int          rises_before;
        logic        cur;
        logic        prev;
        logic [31:0] value;
        logic [31:0] mask;
        logic [31:0] word;
        logic [7:0]  rdat;
        n     = (n_cyc == 5'd0) ? 32 : int'(n_cyc);
        value = $random(seed);
        mask  = (n == 32) ? 32'hffff_ffff : ((32'd1 << n) - 32'd1);
        wb_access(1'b1, REG_CLK_CYCLES, {3'b000, n_cyc}, rdat);
        rises_before = clk_rises;
        k     = 0;
        falls = 0;
        prev  = 1'b0;
        @(posedge CMD_CLK);
        rj45_trigger <= 1'b1;
        while (falls < n)
        begin
            @(negedge CMD_CLK);
            cur = tlu_clock;
            if (!cur && prev)
                falls++;
            if (cur && !prev)
            begin
                // next bit goes out right after the rising edge
                @(posedge CMD_CLK);
                rj45_trigger <= value[k];
                k++;
            end
            prev = cur;
        end
        @(posedge CMD_CLK);
        rj45_trigger <= 1'b0;
        do
            @(negedge CMD_CLK);
        while (tlu_busy);
        check_value("tlu_clock_rises", clk_rises - rises_before, n);
        read_word(REG_TLU_NUM_0, word);
        check_value("tlu_num", word, value & mask);
    endtask

    task automatic build_table();
        add_step(OP_RD, REG_CTRL, 0, 0);
        // only five bits of the cycle field are kept
        add_step(OP_WR, REG_CLK_CYCLES, 32'h35, 0);
        add_step(OP_RD, REG_CLK_CYCLES, 0, 32'h15);
        add_step(OP_RD, 4'd2, 0, 0);
        add_step(OP_WR, 4'd3, 32'haa, 0);
        add_step(OP_RD, 4'd3, 0, 0);
        add_step(OP_RD, 4'd15, 0, 0);
        // LEMO only, RJ45 jack unplugged
        add_step(OP_RJ45, 0, 0, 0);
        add_step(OP_ENABLE, 0, 1, 0);
        add_step(OP_PULSE, `TLU_CH_LEMO_TRIG, 0, 1);
        add_step(OP_PULSE, `TLU_CH_LEMO_TRIG, 0, 1);
        add_step(OP_PULSE, `TLU_CH_LEMO_TRIG, 0, 1);
        add_step(OP_CNT, 0, 0, 3);
        add_step(OP_ENABLE, 0, 0, 0);
        add_step(OP_PULSE, `TLU_CH_LEMO_TRIG, 0, 1);
        add_step(OP_ENABLE, 0, 1, 0);
        add_step(OP_READY, 0, 0, 0);
        add_step(OP_PULSE, `TLU_CH_LEMO_TRIG, 0, 0);
        add_step(OP_READY, 0, 1, 0);
        add_step(OP_CNT, 0, 0, 3);
        add_step(OP_WR, REG_TRIG_CNT_0, 32'h78, 0);
        add_step(OP_WR, REG_TRIG_CNT_1, 32'h56, 0);
        add_step(OP_WR, REG_TRIG_CNT_2, 32'h34, 0);
        add_step(OP_WR, REG_TRIG_CNT_3, 32'h12, 0);
        add_step(OP_CNT, 0, 0, 32'h1234_5678);
        add_step(OP_WR, REG_TRIG_CNT_0, 32'hfe, 0);
        add_step(OP_WR, REG_TRIG_CNT_1, 32'hff, 0);
        add_step(OP_WR, REG_TRIG_CNT_2, 32'hff, 0);
        add_step(OP_WR, REG_TRIG_CNT_3, 32'hff, 0);
        add_step(OP_PULSE, `TLU_CH_LEMO_TRIG, 0, 1);
        add_step(OP_PULSE, `TLU_CH_LEMO_TRIG, 0, 1);
        add_step(OP_CNT, 0, 0, 32'hffff_ffff);
        // TLU reset, first ignored then honoured
        add_step(OP_PULSE, `TLU_CH_LEMO_RST, 0, 0);
        add_step(OP_CNT, 0, 0, 32'hffff_ffff);
        add_step(OP_WR, REG_CTRL, ctrl_byte(TLU_MODE_LEMO_ONLY, 1'b1), 0);
        add_step(OP_TS_SAVE, 0, 0, 0);
        add_step(OP_PULSE, `TLU_CH_LEMO_RST, 0, 0);
        add_step(OP_TS_LESS, 0, 0, 0);
        add_step(OP_CNT, 0, 0, 0);
        add_step(OP_RD, REG_CTRL, 0, ctrl_byte(TLU_MODE_LEMO_ONLY, 1'b1));
        // RJ45 plugged in, no handshake
        add_step(OP_LINES, 0, 0, 0);
        add_step(OP_WR, REG_CTRL, ctrl_byte(TLU_MODE_NO_HS, 1'b0), 0);
        add_step(OP_RJ45, 0, 0, 1);
        add_step(OP_PULSE, `TLU_CH_RJ45_TRIG, 0, 1);
        add_step(OP_PULSE, `TLU_CH_RJ45_TRIG, 0, 1);
        add_step(OP_PULSE, `TLU_CH_LEMO_TRIG, 0, 0);
        add_step(OP_CNT, 0, 0, 2);
        add_step(OP_WR, REG_CTRL, ctrl_byte(TLU_MODE_SIMPLE_HS, 1'b0), 0);
        add_step(OP_HS, 0, 0, 0);
        add_step(OP_CNT, 0, 0, 3);
        add_step(OP_WR, REG_CTRL, ctrl_byte(TLU_MODE_DATA_HS, 1'b0), 0);
        add_step(OP_DATA, 0, 8, 0);
        add_step(OP_DATA, 0, 13, 0);
        add_step(OP_DATA, 0, 0, 0);
        add_step(OP_DATA, 0, 1, 0);
        add_step(OP_CNT, 0, 0, 7);
        add_step(OP_RJ45, 0, 0, 1);
    endtask

    initial
    begin
        step_t       cur;
        logic [7:0]  rdat;
        logic [31:0] word;
        CMD_CLK              = 1'b0;
        RST                  = 1'b1;
        wb_adr               = '0;
        wb_dat_w             = '0;
        wb_we                = 1'b0;
        wb_cyc               = 1'b0;
        wb_stb               = 1'b0;
        // open RJ45 jack reads high
        rj45_trigger         = 1'b1;
        rj45_reset           = 1'b1;
        lemo_trigger         = 1'b0;
        lemo_reset           = 1'b0;
        cmd_ready            = 1'b1;
        cmd_ext_start_enable = 1'b0;
        seed                 = 32'hf1d7;
        check_count          = 0;
        error_count          = 0;
        cycle_count          = 0;
        clk_rises            = 0;
        tlu_clock_q          = 1'b0;
        ts_saved             = '0;
        build_table();
        timeout_limit = steps.size() * ROW_CYCLES;
        repeat (8) @(posedge CMD_CLK);
        RST <= 1'b0;
        foreach (steps[i])
        begin
            cur = steps[i];
            case (cur.op)
                OP_WR:
                    wb_access(1'b1, cur.addr, cur.data[7:0], rdat);
                OP_RD:
                begin
                    wb_access(1'b0, cur.addr, 8'h00, rdat);
                    check_value("wb_dat_r", {24'd0, rdat}, cur.exp);
                end
                OP_CNT:
                begin
                    read_word(REG_TRIG_CNT_0, word);
                    check_value("trig_cnt", word, cur.exp);
                end
                OP_PULSE:
                    pulse_line(cur.addr, cur.exp[0]);
                OP_LINES:
                begin
                    @(posedge CMD_CLK);
                    rj45_trigger <= cur.data[0];
                    rj45_reset   <= cur.data[0];
                    repeat (SETTLE) @(negedge CMD_CLK);
                end
                OP_ENABLE:
                begin
                    @(posedge CMD_CLK);
                    cmd_ext_start_enable <= cur.data[0];
                end
                OP_READY:
                begin
                    @(posedge CMD_CLK);
                    cmd_ready <= cur.data[0];
                end
                OP_RJ45:
                begin
                    @(negedge CMD_CLK);
                    check_value("rj45_enabled", {31'd0, rj45_enabled}, cur.exp);
                end
                OP_TS_SAVE:
                begin
                    @(negedge CMD_CLK);
                    ts_saved = timestamp;
                end
                OP_TS_LESS:
                begin
                    @(negedge CMD_CLK);
                    check_value("timestamp_below_saved", {31'd0, timestamp < ts_saved}, 32'd1);
                end
                OP_HS:
                    run_simple_hs();
                default:
                    run_data_hs(cur.data[4:0]);
            endcase
        end
        $display("checks: %0d errors: %0d", check_count, error_count);
        if (error_count == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
+incdir+hw
hw/tlu_mode_pkg.sv
hw/tlu_regmap_pkg.sv
hw/tlu_input_sync.sv
hw/tlu_port_select.sv
hw/tlu_handshake_fsm.sv
hw/tlu_registers.sv
hw/tlu_controller_top.sv
verification/tlu_controller_properties.sv
verification/tlu_controller_tb.sv

//--- Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert -Wno-fatal
TOP      := tlu_controller_tb
FILELIST := build.f
OBJ_DIR  := obj_dir
LOG      := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with $(SIM) and run $(TOP), fails if the run fails"
	@echo "  clean  remove the build directory and the log"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TB FAILED" $(LOG) || ! grep -q "TB PASSED" $(LOG); then \
		echo "simulation failed"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
